// ==== all.f ====
cpu_pkg.sv
alu.sv
pc.sv
idec.sv
sequencer.sv
cpu.sv
tb_clock.sv
cpu_tb.sv

// ==== alu.sv ====
`timescale 1ns/1ps

module alu (
	input cpu_pkg::data_t a,
	input cpu_pkg::data_t b,
	input cpu_pkg::alu_func_e func,
	input logic cin,
	output cpu_pkg::data_t out,
	output logic cout,
	output logic sign,
	output logic zero,
	output logic ovf
);

cpu_pkg::data_t b_op;

// Subtract adds the complement of B, borrow is the inverted carry
assign b_op = (func == cpu_pkg::alu_sub) ? ~b : b;

always_comb begin
	out = a;
	cout = cin;
	ovf = 1'b0;
	case (func)
		cpu_pkg::alu_pass_a: out = a;
		cpu_pkg::alu_pass_b: out = b;
		cpu_pkg::alu_add, cpu_pkg::alu_sub: begin
			{cout, out} = {1'b0, a} + {1'b0, b_op} + {8'h00, cin};
			ovf = (a[7] == b_op[7]) && (out[7] != a[7]);
		end
		cpu_pkg::alu_and: out = a & b;
		cpu_pkg::alu_or: out = a | b;
		cpu_pkg::alu_xor: out = a ^ b;
		cpu_pkg::alu_inc: out = a + 8'h01;
		cpu_pkg::alu_dec: out = a - 8'h01;
		default: out = a;
	endcase
end

assign sign = out[7];
assign zero = (out == 8'h00);

endmodule

// ==== cpu.sv ====
`timescale 1ns/1ps

module cpu (
	input logic clk,
	input logic reset,
	output logic we,
	output cpu_pkg::addr_t addr,
	inout wire [cpu_pkg::DATA_N - 1:0] data
);

cpu_pkg::ctrl_t ctrl;
cpu_pkg::opcode_e opcode;
cpu_pkg::mode_e mode;

cpu_pkg::data_t ir, ins;
cpu_pkg::data_t acc, x, y, sp, adl, adh;
cpu_pkg::status_u p, p_in, p_din;
cpu_pkg::addr_t pc_val;

cpu_pkg::data_t alu_in_a, alu_in_b, alu_out;
logic alu_cout, alu_sign, alu_zero, alu_ovf;

// Decoder sees the bus byte while it is being fetched
assign ins = ctrl.ir_we ? data : ir;

idec idec0 (.ins(ins), .opcode(opcode), .mode(mode));

sequencer seq0 (.clk(clk), .reset(reset), .opcode(opcode), .mode(mode), .ctrl(ctrl));

// A side operand
always_comb begin
	alu_in_a = '0;
	if (ctrl.abus_a.acc)
		alu_in_a |= acc;
	if (ctrl.abus_a.x)
		alu_in_a |= x;
	if (ctrl.abus_a.sp)
		alu_in_a |= sp;
	if (ctrl.abus_a.p)
		alu_in_a |= p.raw;
	if (ctrl.abus_a.pcl)
		alu_in_a |= pc_val[7:0];
	if (ctrl.abus_a.pch)
		alu_in_a |= pc_val[15:8];
	if (ctrl.abus_a.adl)
		alu_in_a |= adl;
	if (ctrl.abus_a.con)
		alu_in_a |= ctrl.abus_a.consel ? cpu_pkg::CONST_A1 : cpu_pkg::CONST_A0;
end

// B side operand
always_comb begin
	alu_in_b = '0;
	if (ctrl.abus_b.bus)
		alu_in_b |= data;
	if (ctrl.abus_b.con)
		alu_in_b |= ctrl.abus_b.consel ? cpu_pkg::CONST_B1 : cpu_pkg::CONST_B0;
end

alu alu0 (
	.a(alu_in_a), .b(alu_in_b), .func(ctrl.alu_func), .cin(p.f.carry),
	.out(alu_out), .cout(alu_cout), .sign(alu_sign), .zero(alu_zero), .ovf(alu_ovf)
);

pc pc0 (
	.clk(clk), .reset(reset), .inc(ctrl.pc_inc),
	.wel(ctrl.abus_o.pcl), .weh(ctrl.abus_o.pch),
	.in(alu_out), .pc(pc_val)
);

always_ff @(posedge clk) begin
	if (reset) begin
		ir <= '0;
		acc <= '0;
		x <= '0;
		y <= '0;
		sp <= 8'hff;
		adl <= '0;
		adh <= '0;
		p.raw <= '0;
	end else begin
		if (ctrl.ir_we)
			ir <= data;
		if (ctrl.abus_o.acc)
			acc <= alu_out;
		if (ctrl.abus_o.x)
			x <= alu_out;
		if (ctrl.abus_o.y)
			y <= alu_out;
		if (ctrl.abus_o.sp)
			sp <= alu_out;
		if (ctrl.abus_o.adl)
			adl <= alu_out;
		if (ctrl.abus_o.adh)
			adh <= alu_out;
		p <= p_din;
	end
end

// Candidate flags from the ALU
always_comb begin
	p_in.f.sign = alu_sign;
	p_in.f.overflow = alu_ovf;
	p_in.f.one = 1'b1;
	p_in.f.brk = 1'b0;
	p_in.f.decimal = p.f.decimal;
	p_in.f.intr = p.f.intr;
	p_in.f.zero = alu_zero;
	p_in.f.carry = alu_cout;
end

assign p_din.raw = ((~ctrl.flags.mask & p.raw) | (ctrl.flags.mask & p_in.raw)
	| ctrl.flags.set) & ~ctrl.flags.clr;

always_comb begin
	case (ctrl.addr_sel)
		cpu_pkg::as_ad: addr = {adh, adl};
		cpu_pkg::as_zp: addr = {8'h00, adl};
		cpu_pkg::as_stack: addr = {cpu_pkg::STACK_PAGE, sp};
		cpu_pkg::as_vec_lo: addr = cpu_pkg::RESET_VECTOR;
		cpu_pkg::as_vec_hi: addr = cpu_pkg::RESET_VECTOR + 16'h0001;
		cpu_pkg::as_jmp: addr = {pc_val[15:8], adl};
		default: addr = pc_val;
	endcase
end

assign we = ctrl.bus_we;
assign data = ctrl.bus_oe ? alu_out : 'z;

endmodule

// ==== cpu_pkg.sv ====
package cpu_pkg;

	localparam int DATA_N = 8;
	localparam int ADDR_N = 16;

	typedef logic [DATA_N - 1:0] data_t;
	typedef logic [ADDR_N - 1:0] addr_t;

	localparam addr_t RESET_VECTOR = 16'hfffc;
	localparam data_t STACK_PAGE = 8'h01;

	// Constants on the ALU A side
	localparam data_t CONST_A0 = 8'h00;
	localparam data_t CONST_A1 = 8'hff;
	// Constants on the ALU B side, 30 marks the pushed one and brk bits
	localparam data_t CONST_B0 = 8'h01;
	localparam data_t CONST_B1 = 8'h30;

	// Status update masks
	localparam data_t FLAGS_NZ = 8'h82;
	localparam data_t FLAGS_NVZC = 8'hc3;
	localparam data_t FLAG_C = 8'h01;

	typedef enum logic [4:0] {
		op_lda, op_sta, op_adc, op_sbc, op_and, op_ora, op_eor,
		op_ldx, op_ldy, op_tax, op_txa, op_txs, op_inx, op_dex,
		op_clc, op_sec, op_php, op_jmp, op_nop
	} opcode_e;

	typedef enum logic [1:0] {
		md_imp, md_imm, md_zp, md_abs
	} mode_e;

	typedef enum logic [3:0] {
		alu_pass_a, alu_pass_b, alu_add, alu_sub, alu_and,
		alu_or, alu_xor, alu_inc, alu_dec
	} alu_func_e;

	typedef enum logic [2:0] {
		as_pc, as_ad, as_zp, as_stack, as_vec_lo, as_vec_hi, as_jmp
	} addr_sel_e;

	typedef struct packed {
		logic acc;
		logic x;
		logic sp;
		logic p;
		logic pcl;
		logic pch;
		logic adl;
		logic con;
		logic consel;
	} alu_bus_a_t;

	typedef struct packed {
		logic bus;
		logic con;
		logic consel;
	} alu_bus_b_t;

	typedef struct packed {
		logic acc;
		logic x;
		logic y;
		logic sp;
		logic pcl;
		logic pch;
		logic adl;
		logic adh;
	} alu_bus_o_t;

	typedef struct packed {
		data_t mask;
		data_t set;
		data_t clr;
	} flag_mask_t;

	typedef struct packed {
		logic sign;
		logic overflow;
		logic one;
		logic brk;
		logic decimal;
		logic intr;
		logic zero;
		logic carry;
	} status_t;

	typedef union packed {
		data_t raw;
		status_t f;
	} status_u;

	typedef struct packed {
		alu_bus_a_t abus_a;
		alu_bus_b_t abus_b;
		alu_bus_o_t abus_o;
		alu_func_e alu_func;
		flag_mask_t flags;
		logic ir_we;
		logic pc_inc;
		addr_sel_e addr_sel;
		logic bus_we;
		logic bus_oe;
	} ctrl_t;

endpackage

// ==== cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb;

localparam int PROG_N = 60;
localparam int PASSES = 3;
localparam int RESET_LIMIT = 64;
localparam int POOL_N = 34;
localparam cpu_pkg::addr_t PROG_BASE = 16'h0200;

// Opcode pool with STA and PHP twice for more bus traffic
localparam logic [POOL_N * 8 - 1:0] OP_POOL = {
	8'ha9, 8'ha5, 8'had, 8'h85, 8'h8d, 8'h69, 8'h65, 8'h6d, 8'he9, 8'he5, 8'hed,
	8'h29, 8'h25, 8'h2d, 8'h09, 8'h05, 8'h0d, 8'h49, 8'h45, 8'h4d, 8'ha2, 8'ha0,
	8'haa, 8'h8a, 8'h9a, 8'he8, 8'hca, 8'h18, 8'h38, 8'h08, 8'hea,
	8'h85, 8'h8d, 8'h08
};

typedef struct packed {
	cpu_pkg::addr_t addr;
	cpu_pkg::data_t value;
	logic push;
} bus_write_t;

logic clk, reset, we, reset_q;
cpu_pkg::addr_t addr;
wire [cpu_pkg::DATA_N - 1:0] data;

cpu_pkg::data_t mem [0:65535];
cpu_pkg::data_t ref_mem [0:65535];
bus_write_t exp_q [$];
int pass_writes [PASSES];
int pass_cycles;
int value_errors, other_errors;
integer seed;

// Reference model state
cpu_pkg::data_t m_a, m_x, m_y, m_sp;
cpu_pkg::status_u m_p;
cpu_pkg::addr_t m_pc;

tb_clock clkgen (.clk(clk), .reset(reset));

cpu uut (.clk(clk), .reset(reset), .we(we), .addr(addr), .data(data));

// Asynchronous read and a write on the rising edge
assign data = (we === 1'b1) ? 'z : mem[addr];

always @(posedge clk) begin
	reset_q <= reset;
	if (we === 1'b1)
		mem[addr] <= data;
end

function automatic cpu_pkg::addr_t operand_bytes(input cpu_pkg::data_t op);
	if (op == 8'h4c || op[3:0] == 4'hd)
		return 16'd2;
	if (op[3:0] == 4'h5 || op[3:0] == 4'h9 || op == 8'ha2 || op == 8'ha0)
		return 16'd1;
	return 16'd0;
endfunction

function automatic int insn_cycles(input cpu_pkg::data_t op);
	if (op == 8'h4c || op == 8'h08 || op[3:0] == 4'h5)
		return 3;
	if (op[3:0] == 4'hd)
		return 4;
	return 2;
endfunction

task automatic check_addr(input string name, input cpu_pkg::addr_t got,
	input cpu_pkg::addr_t exp);
	if (got !== exp) begin
		value_errors++;
		$display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
	end
endtask

task automatic check_data(input string name, input cpu_pkg::data_t got,
	input cpu_pkg::data_t exp);
	if (got !== exp) begin
		value_errors++;
		$display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
	end
endtask

task automatic check_status(input string name, input cpu_pkg::status_u got,
	input cpu_pkg::status_u exp);
	if (got.raw !== exp.raw) begin
		value_errors++;
		$display("FAIL %s got %h expected %h at %0t", name, got.raw, exp.raw, $time);
	end
endtask

task automatic build_program();
	cpu_pkg::addr_t p;
	cpu_pkg::data_t op;
	int k;
	for (int i = 0; i < 65536; i++)
		mem[i] = 8'h00;
	for (int i = 16'h0010; i < 16'h0040; i++)
		mem[i] = $random(seed);
	for (int i = 16'h0300; i < 16'h0400; i++)
		mem[i] = $random(seed);
	mem[cpu_pkg::RESET_VECTOR] = PROG_BASE[7:0];
	mem[cpu_pkg::RESET_VECTOR + 16'h0001] = PROG_BASE[15:8];
	p = PROG_BASE;
	for (int i = 0; i < PROG_N; i++) begin
		k = $unsigned($random(seed)) % POOL_N;
		op = OP_POOL[k * 8 +: 8];
		mem[p] = op;
		if (op[3:0] == 4'h5) begin
			mem[p + 1] = 8'h10 + $unsigned($random(seed)) % 48;
		end else if (op[3:0] == 4'hd) begin
			mem[p + 1] = $random(seed);
			mem[p + 2] = 8'h03;
		end else if (operand_bytes(op) == 16'd1) begin
			mem[p + 1] = $random(seed);
		end
		p = p + 16'h0001 + operand_bytes(op);
	end
	// Closing jump back to the start
	mem[p] = 8'h4c;
	mem[p + 1] = PROG_BASE[7:0];
	mem[p + 2] = PROG_BASE[15:8];
	for (int i = 0; i < 65536; i++)
		ref_mem[i] = mem[i];
endtask

task automatic set_nz(input cpu_pkg::data_t r);
	m_p.f.sign = r[7];
	m_p.f.zero = (r == 8'h00);
endtask

task automatic add_with_carry(input cpu_pkg::data_t b);
	logic [8:0] sum;
	int signed_sum;
	sum = {1'b0, m_a} + {1'b0, b} + {8'h00, m_p.f.carry};
	// Signed result out of the byte range
	signed_sum = int'($signed(m_a)) + int'($signed(b)) + int'(m_p.f.carry);
	m_p.f.overflow = (signed_sum > 127) || (signed_sum < -128);
	m_p.f.carry = sum[8];
	m_a = sum[7:0];
	set_nz(m_a);
endtask

task automatic expect_write(input cpu_pkg::addr_t a, input cpu_pkg::data_t v, input logic push);
	bus_write_t w;
	w.addr = a;
	w.value = v;
	w.push = push;
	exp_q.push_back(w);
	ref_mem[a] = v;
endtask

// One pass of the program up to and including the closing JMP
task automatic model_pass(output int cycles, output int writes);
	cpu_pkg::addr_t ea;
	cpu_pkg::data_t op, opnd;
	cpu_pkg::status_u pushed;
	logic done;
	cycles = 0;
	writes = 0;
	done = 1'b0;
	while (!done && cycles < 4096) begin
		op = ref_mem[m_pc];
		ea = m_pc + 16'h0001;
		if (op[3:0] == 4'h5)
			ea = {8'h00, ref_mem[ea]};
		else if (op[3:0] == 4'hd || op == 8'h4c)
			ea = {ref_mem[ea + 16'h0001], ref_mem[ea]};
		opnd = ref_mem[ea];
		m_pc = m_pc + 16'h0001 + operand_bytes(op);
		cycles += insn_cycles(op);
		case (op)
			8'ha9, 8'ha5, 8'had: begin
				m_a = opnd;
				set_nz(m_a);
			end
			8'h85, 8'h8d: begin
				expect_write(ea, m_a, 1'b0);
				writes++;
			end
			8'h69, 8'h65, 8'h6d: add_with_carry(opnd);
			// SBC is ADC of the complement
			8'he9, 8'he5, 8'hed: add_with_carry(~opnd);
			8'h29, 8'h25, 8'h2d: begin
				m_a = m_a & opnd;
				set_nz(m_a);
			end
			8'h09, 8'h05, 8'h0d: begin
				m_a = m_a | opnd;
				set_nz(m_a);
			end
			8'h49, 8'h45, 8'h4d: begin
				m_a = m_a ^ opnd;
				set_nz(m_a);
			end
			8'ha2, 8'haa, 8'he8, 8'hca: begin
				if (op == 8'ha2)
					m_x = opnd;
				else if (op == 8'haa)
					m_x = m_a;
				else
					m_x = (op == 8'he8) ? m_x + 8'h01 : m_x - 8'h01;
				set_nz(m_x);
			end
			8'ha0: begin
				m_y = opnd;
				set_nz(m_y);
			end
			8'h8a: begin
				m_a = m_x;
				set_nz(m_a);
			end
			8'h9a: m_sp = m_x;
			8'h18: m_p.f.carry = 1'b0;
			8'h38: m_p.f.carry = 1'b1;
			8'h08: begin
				// Pushed copy carries one and brk
				pushed = m_p;
				pushed.f.one = 1'b1;
				pushed.f.brk = 1'b1;
				expect_write({cpu_pkg::STACK_PAGE, m_sp}, pushed.raw, 1'b1);
				m_sp = m_sp - 8'h01;
				writes++;
			end
			8'h4c: begin
				m_pc = ea;
				done = 1'b1;
			end
			default: ;
		endcase
	end
endtask

initial begin
	int n;
	int pass;
	int count;
	logic prev_we;
	bus_write_t w;
	seed = 32'h89d9_92dd;
	value_errors = 0;
	other_errors = 0;
	reset_q = 1'b1;
	build_program();
	m_a = 8'h00;
	m_x = 8'h00;
	m_y = 8'h00;
	m_sp = 8'hff;
	m_p.raw = 8'h00;
	m_pc = {ref_mem[cpu_pkg::RESET_VECTOR + 16'h0001], ref_mem[cpu_pkg::RESET_VECTOR]};
	for (int i = 0; i < PASSES; i++) begin
		model_pass(n, pass_writes[i]);
		pass_cycles = n;
	end

	// Core parks on the low vector byte while reset is seen
	n = 0;
	while (reset_q === 1'b1 && n < RESET_LIMIT) begin
		@(negedge clk);
		if (reset_q === 1'b1) begin
			if (we !== 1'b0) begin
				other_errors++;
				$display("Error: write strobe not low during reset at %0t", $time);
			end
			check_addr("addr", addr, cpu_pkg::RESET_VECTOR);
		end
		n++;
	end

	if (reset_q === 1'b1) begin
		other_errors++;
		$display("Timeout: reset still active after %0d cycles", RESET_LIMIT);
	end else begin
		check_addr("addr", addr, cpu_pkg::RESET_VECTOR + 16'h0001);
		prev_we = 1'b0;
		count = 0;
		pass = 0;
		for (int c = 0; c <= PASSES * pass_cycles; c++) begin
			@(negedge clk);
			// Every pass opens with the fetch at the program start
			if (c % pass_cycles == 0) begin
				check_addr("addr", addr, PROG_BASE);
				if (c > 0) begin
					if (count != pass_writes[pass]) begin
						other_errors++;
						$display("Error: pass %0d made %0d writes instead of %0d",
							pass, count, pass_writes[pass]);
					end
					pass++;
					count = 0;
				end
			end
			if (we === 1'b1) begin
				count++;
				if (prev_we) begin
					other_errors++;
					$display("Error: write strobe high in two cycles in a row at %0t", $time);
				end
				if (exp_q.size() == 0) begin
					other_errors++;
					$display("Error: write to %h that the model does not make", addr);
				end else begin
					w = exp_q.pop_front();
					check_addr("addr", addr, w.addr);
					if (w.push)
						check_status("data", data, w.value);
					else
						check_data("data", data, w.value);
				end
			end else if (we !== 1'b0) begin
				other_errors++;
				$display("Error: write strobe unknown at %0t", $time);
			end
			prev_we = (we === 1'b1);
		end
		if (exp_q.size() != 0) begin
			other_errors++;
			$display("Error: %0d predicted writes never appeared on the bus", exp_q.size());
		end
	end

	$display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
	if (value_errors == 0 && other_errors == 0)
		$display("Done: no errors");
	else
		$display("Done: errors found");
	$finish;
end

endmodule

// ==== idec.sv ====
`timescale 1ns/1ps

module idec (
	input cpu_pkg::data_t ins,
	output cpu_pkg::opcode_e opcode,
	output cpu_pkg::mode_e mode
);

always_comb begin
	opcode = cpu_pkg::op_nop;
	mode = cpu_pkg::md_imp;
	case (ins)
		8'ha9: begin opcode = cpu_pkg::op_lda; mode = cpu_pkg::md_imm; end
		8'ha5: begin opcode = cpu_pkg::op_lda; mode = cpu_pkg::md_zp; end
		8'had: begin opcode = cpu_pkg::op_lda; mode = cpu_pkg::md_abs; end
		8'h85: begin opcode = cpu_pkg::op_sta; mode = cpu_pkg::md_zp; end
		8'h8d: begin opcode = cpu_pkg::op_sta; mode = cpu_pkg::md_abs; end
		8'h69: begin opcode = cpu_pkg::op_adc; mode = cpu_pkg::md_imm; end
		8'h65: begin opcode = cpu_pkg::op_adc; mode = cpu_pkg::md_zp; end
		8'h6d: begin opcode = cpu_pkg::op_adc; mode = cpu_pkg::md_abs; end
		8'he9: begin opcode = cpu_pkg::op_sbc; mode = cpu_pkg::md_imm; end
		8'he5: begin opcode = cpu_pkg::op_sbc; mode = cpu_pkg::md_zp; end
		8'hed: begin opcode = cpu_pkg::op_sbc; mode = cpu_pkg::md_abs; end
		8'h29: begin opcode = cpu_pkg::op_and; mode = cpu_pkg::md_imm; end
		8'h25: begin opcode = cpu_pkg::op_and; mode = cpu_pkg::md_zp; end
		8'h2d: begin opcode = cpu_pkg::op_and; mode = cpu_pkg::md_abs; end
		8'h09: begin opcode = cpu_pkg::op_ora; mode = cpu_pkg::md_imm; end
		8'h05: begin opcode = cpu_pkg::op_ora; mode = cpu_pkg::md_zp; end
		8'h0d: begin opcode = cpu_pkg::op_ora; mode = cpu_pkg::md_abs; end
		8'h49: begin opcode = cpu_pkg::op_eor; mode = cpu_pkg::md_imm; end
		8'h45: begin opcode = cpu_pkg::op_eor; mode = cpu_pkg::md_zp; end
		8'h4d: begin opcode = cpu_pkg::op_eor; mode = cpu_pkg::md_abs; end
		8'ha2: begin opcode = cpu_pkg::op_ldx; mode = cpu_pkg::md_imm; end
		8'ha0: begin opcode = cpu_pkg::op_ldy; mode = cpu_pkg::md_imm; end
		// Implied group
		8'haa: opcode = cpu_pkg::op_tax;
		8'h8a: opcode = cpu_pkg::op_txa;
		8'h9a: opcode = cpu_pkg::op_txs;
		8'he8: opcode = cpu_pkg::op_inx;
		8'hca: opcode = cpu_pkg::op_dex;
		8'h18: opcode = cpu_pkg::op_clc;
		8'h38: opcode = cpu_pkg::op_sec;
		8'h08: opcode = cpu_pkg::op_php;
		8'hea: opcode = cpu_pkg::op_nop;
		8'h4c: begin opcode = cpu_pkg::op_jmp; mode = cpu_pkg::md_abs; end
		default: begin
			opcode = cpu_pkg::op_nop;
			mode = cpu_pkg::md_imp;
		end
	endcase
end

endmodule

// ==== pc.sv ====
`timescale 1ns/1ps

module pc (
	input logic clk,
	input logic reset,
	input logic inc,
	input logic wel,
	input logic weh,
	input cpu_pkg::data_t in,
	output cpu_pkg::addr_t pc
);

always_ff @(posedge clk) begin
	if (reset) begin
		pc <= '0;
	end else if (inc) begin
		pc <= pc + 16'h0001;
	end else begin
		if (wel)
			pc[7:0] <= in;
		if (weh)
			pc[15:8] <= in;
	end
end

// Increment and byte load come from different cycles
assert property (@(posedge clk) disable iff (reset) !(inc && (wel || weh)));

endmodule

// ==== sequencer.sv ====
`timescale 1ns/1ps

module sequencer (
	input logic clk,
	input logic reset,
	input cpu_pkg::opcode_e opcode,
	input cpu_pkg::mode_e mode,
	output cpu_pkg::ctrl_t ctrl
);

typedef enum logic [2:0] {
	st_vec_lo, st_vec_hi, st_fetch, st_op_lo, st_op_hi, st_mem, st_exec
} state_e;

state_e state, state_next;
logic jmp_fix, jmp_fix_next;

always_ff @(posedge clk) begin
	if (reset) begin
		state <= st_vec_lo;
		jmp_fix <= 1'b0;
	end else begin
		state <= state_next;
		jmp_fix <= jmp_fix_next;
	end
end

always_comb begin
	ctrl = '0;
	state_next = state;
	jmp_fix_next = jmp_fix;
	case (state)
		st_vec_lo: begin
			ctrl.addr_sel = cpu_pkg::as_vec_lo;
			ctrl.abus_b.bus = 1'b1;
			ctrl.alu_func = cpu_pkg::alu_pass_b;
			ctrl.abus_o.pcl = 1'b1;
			state_next = st_vec_hi;
		end
		st_vec_hi: begin
			ctrl.addr_sel = cpu_pkg::as_vec_hi;
			ctrl.abus_b.bus = 1'b1;
			ctrl.alu_func = cpu_pkg::alu_pass_b;
			ctrl.abus_o.pch = 1'b1;
			state_next = st_fetch;
		end
		st_fetch: begin
			ctrl.ir_we = 1'b1;
			if (jmp_fix) begin
				// Target opcode comes from pch:adl, pcl takes adl plus one
				ctrl.addr_sel = cpu_pkg::as_jmp;
				ctrl.abus_a.adl = 1'b1;
				ctrl.alu_func = cpu_pkg::alu_inc;
				ctrl.abus_o.pcl = 1'b1;
			end else begin
				ctrl.addr_sel = cpu_pkg::as_pc;
				ctrl.pc_inc = 1'b1;
			end
			jmp_fix_next = 1'b0;
			if (opcode == cpu_pkg::op_php)
				state_next = st_mem;
			else if (mode == cpu_pkg::md_zp || mode == cpu_pkg::md_abs)
				state_next = st_op_lo;
			else
				state_next = st_exec;
		end
		st_op_lo: begin
			ctrl.addr_sel = cpu_pkg::as_pc;
			ctrl.pc_inc = 1'b1;
			ctrl.abus_b.bus = 1'b1;
			ctrl.alu_func = cpu_pkg::alu_pass_b;
			ctrl.abus_o.adl = 1'b1;
			if (opcode == cpu_pkg::op_jmp)
				state_next = st_exec;
			else if (mode == cpu_pkg::md_abs)
				state_next = st_op_hi;
			else if (opcode == cpu_pkg::op_sta)
				state_next = st_mem;
			else
				state_next = st_exec;
		end
		st_op_hi: begin
			ctrl.addr_sel = cpu_pkg::as_pc;
			ctrl.pc_inc = 1'b1;
			ctrl.abus_b.bus = 1'b1;
			ctrl.alu_func = cpu_pkg::alu_pass_b;
			ctrl.abus_o.adh = 1'b1;
			state_next = (opcode == cpu_pkg::op_sta) ? st_mem : st_exec;
		end
		st_mem: begin
			ctrl.bus_we = 1'b1;
			ctrl.bus_oe = 1'b1;
			if (opcode == cpu_pkg::op_php) begin
				ctrl.addr_sel = cpu_pkg::as_stack;
				ctrl.abus_a.p = 1'b1;
				ctrl.abus_b.con = 1'b1;
				ctrl.abus_b.consel = 1'b1;
				ctrl.alu_func = cpu_pkg::alu_or;
				state_next = st_exec;
			end else begin
				ctrl.addr_sel = (mode == cpu_pkg::md_zp) ? cpu_pkg::as_zp : cpu_pkg::as_ad;
				ctrl.abus_a.acc = 1'b1;
				ctrl.alu_func = cpu_pkg::alu_pass_a;
				state_next = st_fetch;
			end
		end
		st_exec: begin
			state_next = st_fetch;
			case (mode)
				cpu_pkg::md_imm: begin
					ctrl.addr_sel = cpu_pkg::as_pc;
					ctrl.pc_inc = 1'b1;
				end
				cpu_pkg::md_zp: ctrl.addr_sel = cpu_pkg::as_zp;
				cpu_pkg::md_abs: ctrl.addr_sel = cpu_pkg::as_ad;
				default: ctrl.addr_sel = cpu_pkg::as_pc;
			endcase
			ctrl.abus_b.bus = 1'b1;
			case (opcode)
				cpu_pkg::op_lda, cpu_pkg::op_ldx, cpu_pkg::op_ldy: begin
					ctrl.abus_a.con = 1'b1;
					ctrl.abus_a.consel = 1'b1;
					ctrl.alu_func = cpu_pkg::alu_and;
					ctrl.abus_o.acc = (opcode == cpu_pkg::op_lda);
					ctrl.abus_o.x = (opcode == cpu_pkg::op_ldx);
					ctrl.abus_o.y = (opcode == cpu_pkg::op_ldy);
					ctrl.flags.mask = cpu_pkg::FLAGS_NZ;
				end
				cpu_pkg::op_adc, cpu_pkg::op_sbc: begin
					ctrl.abus_a.acc = 1'b1;
					ctrl.alu_func = (opcode == cpu_pkg::op_adc) ?
						cpu_pkg::alu_add : cpu_pkg::alu_sub;
					ctrl.abus_o.acc = 1'b1;
					ctrl.flags.mask = cpu_pkg::FLAGS_NVZC;
				end
				cpu_pkg::op_and, cpu_pkg::op_ora, cpu_pkg::op_eor: begin
					ctrl.abus_a.acc = 1'b1;
					if (opcode == cpu_pkg::op_and)
						ctrl.alu_func = cpu_pkg::alu_and;
					else if (opcode == cpu_pkg::op_ora)
						ctrl.alu_func = cpu_pkg::alu_or;
					else
						ctrl.alu_func = cpu_pkg::alu_xor;
					ctrl.abus_o.acc = 1'b1;
					ctrl.flags.mask = cpu_pkg::FLAGS_NZ;
				end
				cpu_pkg::op_tax: begin
					ctrl.abus_a.acc = 1'b1;
					ctrl.abus_o.x = 1'b1;
					ctrl.flags.mask = cpu_pkg::FLAGS_NZ;
				end
				cpu_pkg::op_txa, cpu_pkg::op_txs: begin
					ctrl.abus_a.x = 1'b1;
					ctrl.abus_o.acc = (opcode == cpu_pkg::op_txa);
					ctrl.abus_o.sp = (opcode == cpu_pkg::op_txs);
					if (opcode == cpu_pkg::op_txa)
						ctrl.flags.mask = cpu_pkg::FLAGS_NZ;
				end
				cpu_pkg::op_inx, cpu_pkg::op_dex: begin
					ctrl.abus_a.x = 1'b1;
					ctrl.alu_func = (opcode == cpu_pkg::op_inx) ?
						cpu_pkg::alu_inc : cpu_pkg::alu_dec;
					ctrl.abus_o.x = 1'b1;
					ctrl.flags.mask = cpu_pkg::FLAGS_NZ;
				end
				cpu_pkg::op_clc: ctrl.flags.clr = cpu_pkg::FLAG_C;
				cpu_pkg::op_sec: ctrl.flags.set = cpu_pkg::FLAG_C;
				cpu_pkg::op_php: begin
					ctrl.abus_a.sp = 1'b1;
					ctrl.alu_func = cpu_pkg::alu_dec;
					ctrl.abus_o.sp = 1'b1;
				end
				cpu_pkg::op_jmp: begin
					// High target byte, low byte waits in adl
					ctrl.addr_sel = cpu_pkg::as_pc;
					ctrl.alu_func = cpu_pkg::alu_pass_b;
					ctrl.abus_o.pch = 1'b1;
					jmp_fix_next = 1'b1;
				end
				default: ctrl.alu_func = cpu_pkg::alu_pass_a;
			endcase
		end
		default: state_next = st_vec_lo;
	endcase
end

assert property (@(posedge clk) reset |-> !ctrl.bus_we);
assert property (@(posedge clk) disable iff (reset) ctrl.bus_we |=> !ctrl.bus_we);

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic reset
);

localparam int RESET_CYCLES = 16;

initial begin
	clk = 1'b0;
	forever #10 clk = ~clk;
end

// Reset drops on the falling edge after the last reset cycle
initial begin
	reset = 1'b1;
	repeat (RESET_CYCLES) @(posedge clk);
	@(negedge clk);
	reset = 1'b0;
end

endmodule
